// ==== compile.f ====
+incdir+source
source/smc_pkg.sv
source/smc_apb_if.sv
source/smc_regs.sv
source/smc_timer.sv
source/smc_fsm.sv
source/smc_datapath.sv
source/smc_top.sv
tb/tb_clkgen.sv
tb/smc_mem_model.sv
tb/smc_tb.sv

// ==== tb/smc_tb.sv ====
// SMC testbench: directed APB and host access tests against a behavioral SRAM
`timescale 1ns/1ps

`include "smc_cfg.svh"

module smc_tb
  import smc_pkg::*;
();

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 10;
  localparam int N_ACCESS        = 64;  // Upper bound on host accesses
  localparam int ACCESS_MAX      = 40;  // 1 + 16 strobe + 1 + 8 stall + 3 turn, rounded up
  localparam int N_APB           = 40;  // Upper bound on APB transfers
  localparam int APB_CYCLES      = 4;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_ACCESS * ACCESS_MAX
                                   + N_APB * APB_CYCLES + 500;

  logic                    pclk;
  logic                    rst_n;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`SMC_PADDR_W-1:0] paddr;
  logic [`SMC_DATA_W-1:0]  pwdata;
  logic [`SMC_DATA_W-1:0]  prdata;
  smc_req_t                req;
  logic                    req_valid;
  logic                    req_ready;
  smc_rsp_t                rsp;
  logic                    rsp_valid;
  logic                    rsp_ready;
  smc_mem_t                mem;
  logic [`SMC_DATA_W-1:0]  mem_rdata;

  integer seed = 32'h72d60179;
  string  test_name = "init";
  int     tests;
  int     checks;
  int     errors;
  int     chk_mark;
  int     err_mark;
  int     completions;  // Responses taken by the host

  tb_clkgen #(.PERIOD(CLK_PERIOD)) u_clkgen (.clk(pclk));

  smc_top smc_top_i (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .mem       (mem),
    .mem_rdata (mem_rdata)
  );

  smc_mem_model u_mem (.mem(mem), .rdata(mem_rdata));

  // ------------------------------
  // Reporting and compares
  // ------------------------------
  task automatic report_error(input string msg);
    errors++;
    $display("ERROR %s: %s", test_name, msg);
  endtask

  task automatic check_flag(input logic ok, input string msg);
    checks++;
    if (ok !== 1'b1)
      report_error(msg);
  endtask

  task automatic cmp_word(input string what, input logic [`SMC_DATA_W-1:0] exp,
                          input logic [`SMC_DATA_W-1:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("FAILED %s: %s expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic cmp_count(input string what, input logic [`SMC_CNT_W-1:0] exp,
                           input logic [`SMC_CNT_W-1:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("FAILED %s: %s expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic cmp_cycles(input string what, input int exp, input int act);
    checks++;
    if (act != exp)
    begin
      errors++;
      $display("FAILED %s: %s expected %0d cycles, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    chk_mark  = checks;
    err_mark  = errors;
    tests++;
  endtask

  task automatic finish_test();
    $display("%-16s %0d checks, %0d errors", test_name, checks - chk_mark, errors - err_mark);
  endtask

  // Config word in the field layout: turn [9:8], wr_wait [7:4], rd_wait [3:0]
  function automatic logic [`SMC_DATA_W-1:0] timing_word(input int rd, input int wr,
                                                         input int turn);
    return ((turn & 3) << 8) | ((wr & 15) << 4) | (rd & 15);
  endfunction

  // ------------------------------
  // Bus drivers
  // ------------------------------
  task automatic next_cycle();
    @(posedge pclk);
    #2;  // Drive point after the edge
  endtask

  // Setup cycle, then access cycle, write lands at its closing edge
  task automatic apb_write(input logic [`SMC_PADDR_W-1:0] addr,
                           input logic [`SMC_DATA_W-1:0] data);
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    next_cycle();
    penable = 1'b1;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [`SMC_PADDR_W-1:0] addr,
                          output logic [`SMC_DATA_W-1:0] data);
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = addr;
    next_cycle();
    penable = 1'b1;
    #10;
    data = prdata;  // Combinational, settled mid access phase
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic offer_req(input logic write, input logic [`SMC_ADDR_W-1:0] addr,
                           input logic [`SMC_DATA_W-1:0] wdata);
    req.write = write;
    req.addr  = addr;
    req.wdata = wdata;
    req_valid = 1'b1;
  endtask

  // Held until req_ready, handshake at the following edge
  task automatic accept_req();
    while (req_ready !== 1'b1)
      next_cycle();
    next_cycle();
    req_valid = 1'b0;
  endtask

  task automatic send_req(input logic write, input logic [`SMC_ADDR_W-1:0] addr,
                          input logic [`SMC_DATA_W-1:0] wdata);
    offer_req(write, addr, wdata);
    accept_req();
  endtask

  // Waits for rsp_valid, stalls hold cycles, then takes the response
  task automatic take_rsp(input int hold, output logic [`SMC_DATA_W-1:0] rdata);
    while (rsp_valid !== 1'b1)
      next_cycle();
    repeat (hold)
      next_cycle();
    rsp_ready = 1'b1;
    rdata     = rsp.rdata;
    next_cycle();
    rsp_ready = 1'b0;
    completions++;
  endtask

  task automatic host_access(input logic write, input logic [`SMC_ADDR_W-1:0] addr,
                             input logic [`SMC_DATA_W-1:0] wdata, input int hold,
                             output logic [`SMC_DATA_W-1:0] rdata);
    send_req(write, addr, wdata);
    take_rsp(hold, rdata);
  endtask

  // ------------------------------
  // Monitor, sampled mid-cycle
  // ------------------------------
  int       cyc;
  int       strobe_run;     // Low cycles of current strobe
  int       last_strobe_w;
  int       strobe_total;
  int       acc_cyc;        // Cycle ending in the req handshake
  int       last_latency;
  logic     rsp_seen;
  logic     prev_valid;
  logic     prev_ready;
  smc_rsp_t prev_rsp;

  always @(negedge pclk)
  begin
    if (!rst_n)
    begin
      cyc          = 0;
      strobe_run   = 0;
      strobe_total = 0;
      acc_cyc      = 0;
      rsp_seen     = 1'b1;
      prev_valid   = 1'b0;
      prev_ready   = 1'b0;
    end
    else
    begin
      cyc++;
      if (mem.cs_n === 1'b0)
      begin
        strobe_run++;
        if (mem.oe_n === mem.we_n)
          report_error("chip select low without exactly one of oe_n and we_n low");
      end
      else if (strobe_run != 0)
      begin
        last_strobe_w = strobe_run;  // Strobe just ended
        strobe_total++;
        strobe_run = 0;
      end
      if (req_valid && req_ready)
      begin
        acc_cyc  = cyc;
        rsp_seen = 1'b0;
      end
      if (rsp_valid && !rsp_seen)
      begin
        last_latency = cyc - acc_cyc;
        rsp_seen     = 1'b1;
      end
      if (rsp_valid)
      begin
        if (req_ready)
          report_error("req_ready high while a response waits");
        if (mem.cs_n === 1'b0)
          report_error("memory strobe active while a response waits");
        if (prev_valid && !prev_ready && rsp !== prev_rsp)
          report_error("rsp changed while rsp_ready was low");
      end
      prev_valid = rsp_valid;
      prev_ready = rsp_ready;
      prev_rsp   = rsp;
    end
  end

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic reset_state();
    logic [`SMC_DATA_W-1:0] rd;
    start_test("reset_state");
    check_flag(mem.cs_n && mem.oe_n && mem.we_n, "memory strobes not idle after reset");
    check_flag(!rsp_valid, "rsp_valid high after reset");
    check_flag(req_ready, "req_ready low after reset");
    apb_read(`SMC_REG_CFG, rd);
    cmp_word("cfg reset value", timing_word(2, 2, 1), rd);
    apb_read(`SMC_REG_STAT, rd);
    cmp_word("stat reset value", '0, rd);
    finish_test();
  endtask

  task automatic register_access();
    logic [`SMC_PADDR_W-1:0] unmapped [3] = '{5'h01, 5'h08, 5'h1c};
    logic [`SMC_DATA_W-1:0]  w;
    logic [`SMC_DATA_W-1:0]  rd;
    int                      i;
    start_test("register_access");
    w = $random(seed);
    apb_write(`SMC_REG_CFG, w);
    apb_read(`SMC_REG_CFG, rd);
    cmp_word("cfg readback", w & 32'h0000_03ff, rd);  // Timing fields only
    for (i = 0; i < 3; i++)
    begin
      apb_read(unmapped[i], rd);
      cmp_word("unmapped read", '0, rd);
    end
    apb_write(5'h08, $random(seed));
    apb_read(`SMC_REG_CFG, rd);
    cmp_word("cfg after unmapped write", w & 32'h0000_03ff, rd);
    apb_write(`SMC_REG_STAT, $random(seed));  // Read-only target
    apb_read(`SMC_REG_STAT, rd);
    cmp_count("stat after write", `SMC_CNT_W'(completions), rd[`SMC_CNT_W-1:0]);
    apb_write(`SMC_REG_CFG, timing_word(2, 2, 1));
    finish_test();
  endtask

  task automatic data_integrity();
    logic [`SMC_DATA_W-1:0] wdata [20];
    logic [`SMC_ADDR_W-1:0] addr;
    logic [`SMC_DATA_W-1:0] rd;
    int                     i;
    start_test("data_integrity");
    for (i = 0; i < 20; i++)
    begin
      addr     = `SMC_ADDR_W'(i * 12 + 3);  // Distinct words
      wdata[i] = $random(seed);
      host_access(1'b1, addr, wdata[i], 0, rd);
      cmp_word("write response", '0, rd);
    end
    for (i = 0; i < 20; i++)
    begin
      addr = `SMC_ADDR_W'(i * 12 + 3);
      host_access(1'b0, addr, '0, 0, rd);
      cmp_word("read data", wdata[i], rd);
    end
    finish_test();
  endtask

  task automatic wait_states();
    int                     waits [3] = '{0, 5, 15};
    logic [`SMC_DATA_W-1:0] wd;
    logic [`SMC_DATA_W-1:0] rd;
    int                     i;
    int                     nr;
    int                     nw;
    start_test("wait_states");
    for (i = 0; i < 3; i++)
    begin
      nr = waits[i];
      nw = waits[2 - i];  // Unequal pairs show the read/write select
      apb_write(`SMC_REG_CFG, timing_word(nr, nw, 1));
      wd = $random(seed);
      host_access(1'b1, 16'h00f0, wd, 0, rd);
      cmp_cycles("write strobe width", nw + 1, last_strobe_w);
      cmp_cycles("write latency", nw + 2, last_latency);
      host_access(1'b0, 16'h00f0, '0, 0, rd);
      cmp_cycles("read strobe width", nr + 1, last_strobe_w);
      cmp_cycles("read latency", nr + 2, last_latency);
      cmp_word("read data", wd, rd);
    end
    finish_test();
  endtask

  task automatic back_pressure();
    logic [`SMC_ADDR_W-1:0] addr;
    logic [`SMC_DATA_W-1:0] wd;
    logic [`SMC_DATA_W-1:0] rd;
    int                     strobes_before;
    int                     i;
    start_test("back_pressure");
    apb_write(`SMC_REG_CFG, timing_word(3, 3, 2));
    for (i = 0; i < 3; i++)
    begin
      addr           = `SMC_ADDR_W'(16'h0080 + i);
      wd             = $random(seed);
      strobes_before = strobe_total;
      send_req(1'b1, addr, wd);
      offer_req(1'b0, addr, '0);  // Second request waits behind the stall
      take_rsp(1 + $unsigned($random(seed)) % 8, rd);
      cmp_word("stalled write response", '0, rd);
      accept_req();
      take_rsp(1 + $unsigned($random(seed)) % 8, rd);
      cmp_word("stalled read data", wd, rd);
      cmp_cycles("read strobe width", 4, last_strobe_w);
      cmp_cycles("strobes per pair", 2, strobe_total - strobes_before);
    end
    finish_test();
  endtask

  task automatic access_count();
    logic [`SMC_DATA_W-1:0] rd;
    start_test("access_count");
    apb_read(`SMC_REG_STAT, rd);
    cmp_count("completed accesses", `SMC_CNT_W'(completions), rd[`SMC_CNT_W-1:0]);
    apb_write(`SMC_REG_CFG, timing_word(4, 4, 1));
    send_req(1'b0, 16'h0040, '0);
    apb_write(`SMC_REG_CFG, timing_word(9, 9, 1));  // Lands inside the strobe
    take_rsp(0, rd);
    cmp_cycles("strobe width across cfg write", 5, last_strobe_w);
    host_access(1'b0, 16'h0041, '0, 0, rd);
    cmp_cycles("strobe width with new cfg", 10, last_strobe_w);
    apb_read(`SMC_REG_STAT, rd);
    cmp_count("completed accesses", `SMC_CNT_W'(completions), rd[`SMC_CNT_W-1:0]);
    finish_test();
  endtask

  // ------------------------------
  // Sequence and watchdog
  // ------------------------------
  initial
  begin
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    req       = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b0;
    repeat (RESET_CYCLES) @(posedge pclk);
    #2;
    rst_n = 1'b1;
    next_cycle();
    reset_state();
    register_access();
    data_integrity();
    wait_states();
    back_pressure();
    access_count();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge pclk);
    $display("Timeout in %s: run did not finish within %0d cycles", test_name,
             WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== tb/smc_mem_model.sv ====
// Behavioral asynchronous SRAM: 256 words on the SMC memory bus
`timescale 1ns/1ps

`include "smc_cfg.svh"

module smc_mem_model
  import smc_pkg::*;
(
  input  smc_mem_t               mem,    // Strobes, address, write data
  output logic [`SMC_DATA_W-1:0] rdata   // Driven only while selected for read
);

  localparam int DEPTH = 256;

  logic [`SMC_DATA_W-1:0] words [DEPTH];
  logic                   we_n;

  assign we_n = mem.we_n;

  // Power-up image, every word tied to its own address
  initial
  begin
    int i;
    for (i = 0; i < DEPTH; i++)
      words[i] = 32'h9e37_79b9 * (i + 1);
  end

  // ------------------------------
  // Write, latched on rising we_n
  // ------------------------------
  // Address and data are still held by the controller at this edge
  always @(posedge we_n)
  begin
    if (!$isunknown(mem.addr))
      words[mem.addr[7:0]] <= mem.wdata;  // Upper address bits wrap
  end

  // Read, floating bus outside an output-enabled cycle
  assign rdata = (mem.cs_n === 1'b0 && mem.oe_n === 1'b0) ? words[mem.addr[7:0]] : 'x;

endmodule

// ==== tb/tb_clkgen.sv ====
// Testbench clock source: free-running clock with a fixed period
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD = 40  // ns
) (
  output logic clk
);

  // Starts low, first rising edge at half a period
  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD / 2) clk = ~clk;
  end

endmodule

// ==== source/smc_top.sv ====
// SMC top level: APB registers, host request channel and memory bus
`timescale 1ns/1ps

`include "smc_cfg.svh"

module smc_top
  import smc_pkg::*;
(
  input  logic                    pclk,
  input  logic                    rst_n,
  // APB
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`SMC_PADDR_W-1:0] paddr,
  input  logic [`SMC_DATA_W-1:0]  pwdata,
  output logic [`SMC_DATA_W-1:0]  prdata,
  // Host
  input  smc_req_t                req,
  input  logic                    req_valid,
  output logic                    req_ready,
  output smc_rsp_t                rsp,
  output logic                    rsp_valid,
  input  logic                    rsp_ready,
  // Memory
  output smc_mem_t                mem,
  input  logic [`SMC_DATA_W-1:0]  mem_rdata
);

  // ------------------------------
  // Internal nets
  // ------------------------------
  smc_cfg_u               cfg;
  logic [`SMC_CNT_W-1:0]  stat_count;
  logic                   sel_cfg;
  logic                   sel_stat;
  logic                   wr_en;
  logic                   acc_done;
  logic                   timer_load;
  logic [`SMC_WAIT_W-1:0] timer_value;
  logic                   timer_done;
  logic                   capture_req;
  logic                   strobe;
  logic                   capture_rd;
  logic                   req_write;

  smc_apb_if u_apb_if (
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .cfg        (cfg),
    .stat_count (stat_count),
    .sel_cfg    (sel_cfg),
    .sel_stat   (sel_stat),
    .wr_en      (wr_en),
    .prdata     (prdata)
  );

  smc_regs u_regs (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .sel_cfg    (sel_cfg),
    .sel_stat   (sel_stat),
    .wr_en      (wr_en),
    .acc_done   (acc_done),
    .pwdata     (pwdata),
    .cfg        (cfg),
    .stat_count (stat_count)
  );

  smc_fsm u_fsm (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .rsp_ready   (rsp_ready),
    .timer_done  (timer_done),
    .req_write   (req_write),
    .cfg         (cfg),
    .req_ready   (req_ready),
    .rsp_valid   (rsp_valid),
    .capture_req (capture_req),
    .strobe      (strobe),
    .capture_rd  (capture_rd),
    .timer_load  (timer_load),
    .acc_done    (acc_done),
    .timer_value (timer_value)
  );

  smc_timer u_timer (
    .pclk  (pclk),
    .rst_n (rst_n),
    .load  (timer_load),
    .value (timer_value),
    .done  (timer_done)
  );

  smc_datapath u_datapath (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .capture_req (capture_req),
    .strobe      (strobe),
    .capture_rd  (capture_rd),
    .req         (req),
    .mem_rdata   (mem_rdata),
    .mem         (mem),
    .rsp         (rsp),
    .req_write   (req_write)
  );

endmodule

// ==== source/smc_datapath.sv ====
// SMC datapath: request registers, memory bus strobes and read data capture
`timescale 1ns/1ps

`include "smc_cfg.svh"

module smc_datapath
  import smc_pkg::*;
(
  input  logic                   pclk,
  input  logic                   rst_n,
  input  logic                   capture_req,  // Request accepted this edge
  input  logic                   strobe,       // Hold strobes active
  input  logic                   capture_rd,   // End of strobe phase
  input  smc_req_t               req,
  input  logic [`SMC_DATA_W-1:0] mem_rdata,
  output smc_mem_t               mem,
  output smc_rsp_t               rsp,
  output logic                   req_write     // Direction for wait select
);

  logic                   cs_n_q;
  logic                   oe_n_q;
  logic                   we_n_q;
  logic                   write_q;   // Direction of access in flight
  logic [`SMC_ADDR_W-1:0] addr_q;
  logic [`SMC_DATA_W-1:0] wdata_q;

  // Host holds req stable while valid, so the live flag is safe here
  assign req_write = req.write;

  // ------------------------------
  // Request registers
  // ------------------------------
  always_ff @(posedge pclk)
  begin
    if (capture_req)
    begin
      write_q <= req.write;
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
    end
  end

  // ------------------------------
  // Strobes, registered
  // ------------------------------
  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cs_n_q <= 1'b1;
      oe_n_q <= 1'b1;
      we_n_q <= 1'b1;
    end
    else if (capture_req)
    begin
      cs_n_q <= 1'b0;         // Low from cycle 1
      oe_n_q <= req.write;    // Read enable
      we_n_q <= ~req.write;   // Write enable
    end
    else if (!strobe)
    begin
      cs_n_q <= 1'b1;         // Bus idle outside ACCESS
      oe_n_q <= 1'b1;
      we_n_q <= 1'b1;
    end
  end

  // Read data sampled while oe_n still low
  always_ff @(posedge pclk)
  begin
    if (capture_rd)
      rsp.rdata <= write_q ? '0 : mem_rdata;
  end

  assign mem.cs_n  = cs_n_q;
  assign mem.oe_n  = oe_n_q;
  assign mem.we_n  = we_n_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  // No bus contention at the memory
  a_oe_we_excl: assert property (@(posedge pclk) disable iff (!rst_n)
    !(!mem.oe_n && !mem.we_n));

endmodule

// ==== source/smc_fsm.sv ====
// SMC access sequencer: request, strobe, response and turnaround phases
`timescale 1ns/1ps

`include "smc_cfg.svh"

module smc_fsm
  import smc_pkg::*;
(
  input  logic                   pclk,
  input  logic                   rst_n,
  input  logic                   req_valid,    // Host request pending
  input  logic                   rsp_ready,    // Host takes response
  input  logic                   timer_done,
  input  logic                   req_write,    // Direction of pending request
  input  smc_cfg_u               cfg,
  output logic                   req_ready,
  output logic                   rsp_valid,
  output logic                   capture_req,  // Register request, start strobes
  output logic                   strobe,       // Keep strobes low next cycle
  output logic                   capture_rd,   // Sample memory read data
  output logic                   timer_load,
  output logic                   acc_done,
  output logic [`SMC_WAIT_W-1:0] timer_value
);

  smc_state_e             state;
  smc_state_e             state_nxt;
  logic [`SMC_TURN_W-1:0] turn_q;     // Turnaround latched at acceptance
  logic                   rsp_hs;     // Response handshake

  // ------------------------------
  // Control decode
  // ------------------------------
  assign req_ready   = (state == IDLE);
  assign rsp_valid   = (state == RESP);
  assign capture_req = req_ready & req_valid;
  assign strobe      = (state == ACCESS) & ~timer_done;
  assign capture_rd  = (state == ACCESS) & timer_done;  // Last strobe cycle
  assign rsp_hs      = rsp_valid & rsp_ready;
  assign acc_done    = rsp_hs;

  // Timer reload: wait count at acceptance, turn-1 at handshake
  assign timer_load = capture_req | (rsp_hs & (turn_q != '0));

  always_comb
  begin
    if (state == IDLE)
      timer_value = req_write ? cfg.timing.wr_wait : cfg.timing.rd_wait;
    else
      timer_value = {{(`SMC_WAIT_W-`SMC_TURN_W){1'b0}}, turn_q} - 1'b1;
  end

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:   if (req_valid)  state_nxt = ACCESS;
      ACCESS: if (timer_done) state_nxt = RESP;
      RESP:
      begin
        if (rsp_ready)
          state_nxt = (turn_q != '0) ? TURN : IDLE;  // Skip TURN for zero
      end
      TURN:   if (timer_done) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state  <= IDLE;
      turn_q <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (capture_req)
        turn_q <= cfg.timing.turn;  // Later config writes wait for next access
    end
  end

  // Strobe request always leaves the machine in ACCESS for another cycle
  a_strobe_access: assert property (@(posedge pclk) disable iff (!rst_n)
    strobe |=> (state == ACCESS));

  // Response held until the host accepts it
  a_rsp_hold: assert property (@(posedge pclk) disable iff (!rst_n)
    $fell(rsp_valid) |-> $past(rsp_ready));

endmodule

// ==== source/smc_timer.sv ====
// SMC wait timer: loadable down-counter for strobe and turnaround phases
`timescale 1ns/1ps

`include "smc_cfg.svh"

module smc_timer (
  input  logic                  pclk,
  input  logic                  rst_n,
  input  logic                  load,   // Start a new count
  input  logic [`SMC_WAIT_W-1:0] value,  // Cycles until done
  output logic                  done    // Count at zero
);

  logic [`SMC_WAIT_W-1:0] count;

  // ------------------------------
  // Down-counter
  // ------------------------------
  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
      count <= '0;
    else if (load)
      count <= value;
    else if (count != '0)
      count <= count - 1'b1;  // Parks at zero
  end

  // Done value cycles after load, high at once for zero
  assign done = (count == '0);

  // One phase at a time, sequencer never reloads a running count
  a_load_idle: assert property (@(posedge pclk) disable iff (!rst_n)
    load |-> (count == '0));

endmodule

// ==== source/smc_regs.sv ====
// SMC register block: timing configuration and completed-access counter
`timescale 1ns/1ps

`include "smc_cfg.svh"

module smc_regs
  import smc_pkg::*;
(
  input  logic                   pclk,
  input  logic                   rst_n,
  input  logic                   sel_cfg,     // From APB decode
  input  logic                   sel_stat,
  input  logic                   wr_en,
  input  logic                   acc_done,    // Pulse per completed access
  input  logic [`SMC_DATA_W-1:0] pwdata,
  output smc_cfg_u               cfg,
  output logic [`SMC_CNT_W-1:0]  stat_count
);

  smc_cfg_u wdata_u;  // APB write data seen as timing fields

  assign wdata_u.raw = pwdata;

  // ------------------------------
  // Configuration register
  // ------------------------------
  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cfg.raw            <= '0;
      cfg.timing.rd_wait <= `SMC_WAIT_W'(`SMC_RST_RD_WAIT);
      cfg.timing.wr_wait <= `SMC_WAIT_W'(`SMC_RST_WR_WAIT);
      cfg.timing.turn    <= `SMC_TURN_W'(`SMC_RST_TURN);
    end
    else if (sel_cfg && wr_en)
    begin
      // Only timing fields written so rsvd stays zero
      cfg.timing.rd_wait <= wdata_u.timing.rd_wait;
      cfg.timing.wr_wait <= wdata_u.timing.wr_wait;
      cfg.timing.turn    <= wdata_u.timing.turn;
    end
  end

  // ------------------------------
  // Access counter
  // ------------------------------
  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
      stat_count <= '0;
    else if (acc_done)
      stat_count <= stat_count + 1'b1;  // Wraps at 16 bits
  end

  // Decode drives at most one register select
  a_sel_onehot: assert property (@(posedge pclk) disable iff (!rst_n)
    !(sel_cfg && sel_stat));

endmodule

// ==== source/smc_apb_if.sv ====
// SMC APB slave: decodes register selects and drives read data onto prdata
`timescale 1ns/1ps

`include "smc_cfg.svh"

module smc_apb_if
  import smc_pkg::*;
(
  input  logic                   psel,        // APB select
  input  logic                   penable,     // Access phase
  input  logic                   pwrite,      // APB write strobe
  input  logic [`SMC_PADDR_W-1:0] paddr,
  input  logic [`SMC_DATA_W-1:0] pwdata,
  input  smc_cfg_u               cfg,         // Current config word
  input  logic [`SMC_CNT_W-1:0]  stat_count,  // Completed accesses
  output logic                   sel_cfg,     // Config register selected
  output logic                   sel_stat,    // Status register selected
  output logic                   wr_en,       // Write in access phase
  output logic [`SMC_DATA_W-1:0] prdata
);

  logic access;  // APB access phase without wait states

  assign access = psel & penable;
  assign wr_en  = access & pwrite;

  // ------------------------------
  // Register selects
  // ------------------------------
  always_comb
  begin
    sel_cfg  = 1'b0;
    sel_stat = 1'b0;
    if (access)
    begin
      // Unmapped address leaves both selects low
      if (paddr == `SMC_REG_CFG)
        sel_cfg = 1'b1;
      else if (paddr == `SMC_REG_STAT)
        sel_stat = 1'b1;
    end
  end

  // ------------------------------
  // Read data mux
  // ------------------------------
  always_comb
  begin
    if (sel_cfg)
      prdata = cfg.raw;                                       // Reserved bits already zero
    else if (sel_stat)
      prdata = {{(`SMC_DATA_W-`SMC_CNT_W){1'b0}}, stat_count};
    else
      prdata = '0;                                            // Idle or unmapped
  end

endmodule

// ==== source/smc_pkg.sv ====
// SMC shared types: host request and response, memory bus, configuration word
package smc_pkg;

  `include "smc_cfg.svh"

  // ------------------------------
  // Configuration word
  // ------------------------------
  typedef struct packed {
    logic [21:0]              rsvd;     // Reads as zero
    logic [`SMC_TURN_W-1:0]   turn;     // [9:8]
    logic [`SMC_WAIT_W-1:0]   wr_wait;  // [7:4]
    logic [`SMC_WAIT_W-1:0]   rd_wait;  // [3:0]
  } smc_timing_t;

  // APB side sees raw, controller sees timing
  typedef union packed {
    logic [`SMC_DATA_W-1:0] raw;
    smc_timing_t            timing;
  } smc_cfg_u;

  // ------------------------------
  // Host channels
  // ------------------------------
  typedef struct packed {
    logic                   write;  // 1 = write, 0 = read
    logic [`SMC_ADDR_W-1:0] addr;
    logic [`SMC_DATA_W-1:0] wdata;
  } smc_req_t;

  typedef struct packed {
    logic [`SMC_DATA_W-1:0] rdata;  // Zero on write responses
  } smc_rsp_t;

  // Memory bus outputs, strobes active low
  typedef struct packed {
    logic                   cs_n;
    logic                   oe_n;
    logic                   we_n;
    logic [`SMC_ADDR_W-1:0] addr;
    logic [`SMC_DATA_W-1:0] wdata;
  } smc_mem_t;

  // Access sequencer states
  typedef enum logic [1:0] {
    IDLE,    // Ready for a request
    ACCESS,  // Strobes on the bus
    RESP,    // Response waiting for host
    TURN     // Bus turnaround
  } smc_state_e;

endpackage

// ==== source/smc_cfg.svh ====
// SMC configuration macros: bus widths, APB register map and reset timing
`ifndef SMC_CFG_SVH
`define SMC_CFG_SVH

// ------------------------------
// Widths
// ------------------------------
`define SMC_ADDR_W      16     // Memory address bus
`define SMC_DATA_W      32     // Memory and APB data
`define SMC_PADDR_W     5      // APB address bus
`define SMC_WAIT_W      4      // Wait state fields and timer
`define SMC_TURN_W      2      // Turnaround field
`define SMC_CNT_W       16     // Completed access counter

// ------------------------------
// APB register map
// ------------------------------
`define SMC_REG_CFG     5'h00  // Timing configuration, R/W
`define SMC_REG_STAT    5'h04  // Access count, read only

// ------------------------------
// Reset timing
// ------------------------------
`define SMC_RST_RD_WAIT 2      // Read wait states
`define SMC_RST_WR_WAIT 2      // Write wait states
`define SMC_RST_TURN    1      // Bus turnaround cycles

`endif
